//--- verilog/stepper_pkg.sv
package stepper_pkg;

  // Data path widths
  localparam int PHASE_W = 8;              // 256 positions per electrical cycle
  localparam int MAG_W   = 8;              // Cosine magnitude
  localparam int CUR_W   = 4;              // Current setting
  localparam int DUTY_W  = MAG_W + CUR_W;  // Magnitude times current, also carrier width

  // Table geometry
  localparam int QUAD_STEPS = 64;  // Positions per quadrant
  localparam int LUT_DEPTH  = 64;  // Quarter wave only
  localparam int LUT_IDX_W  = $clog2(LUT_DEPTH);

  // Binary ROM image, index 0 holds the peak
  localparam string LUT_FILE = "cos_lut.mem";

  typedef logic [PHASE_W-1:0]   phase_t;    // Electrical angle
  typedef logic [MAG_W-1:0]     mag_t;      // Table entry
  typedef logic [CUR_W-1:0]     cur_t;      // Current scale
  typedef logic [DUTY_W-1:0]    duty_t;     // PWM compare value
  typedef logic [LUT_IDX_W-1:0] lut_idx_t;  // Folded table index

endpackage

//--- verilog/bridge_pkg.sv
package bridge_pkg;

  // Bridge drive modes
  typedef enum logic [1:0] {
    ST_OFF   = 2'd0,  // Coast
    ST_BRAKE = 2'd1,  // Both low sides shorted via all legs high
    ST_RUN   = 2'd2   // Normal stepping
  } drive_state_t;

  // Leg bits {b2, b1, a2, a1}
  typedef logic [3:0] legs_t;

  // Drive polarity per quadrant of the phase
  localparam legs_t QUAD_LEGS [4] = '{
    4'b1010,  // Quadrant 0
    4'b0110,  // Quadrant 1
    4'b0101,  // Quadrant 2
    4'b1001   // Quadrant 3
  };

  // Hold both legs high while vref is low
  localparam logic SLOW_DECAY = 1'b1;

endpackage

//--- verilog/drive_fsm.sv
`timescale 1ns/1ps

module drive_fsm (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     step,        // Raw step level, async to clk
  input  logic                     enable,
  input  logic                     brake,
  output bridge_pkg::drive_state_t mode,
  output logic                     step_pulse   // One cycle per accepted rising edge
);

  import bridge_pkg::*;

  drive_state_t state;
  drive_state_t state_next;
  logic [1:0]   step_sync;  // Two-flop synchronizer
  logic         step_last;  // Synced level one clock back

  // Enable wins over brake, brake only matters while disabled
  always_comb begin
    state_next = state;
    case (state)
      ST_OFF, ST_BRAKE, ST_RUN: begin
        if (enable) begin
          state_next = ST_RUN;
        end else if (brake) begin
          state_next = ST_BRAKE;  // Short the coils
        end else begin
          state_next = ST_OFF;    // Coast
        end
      end
      default: begin
        state_next = ST_OFF;  // Unused encoding recovers to coast
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (resetn) begin
      state     <= ST_OFF;
      step_sync <= 2'b00;
      step_last <= 1'b0;
    end else begin
      state     <= state_next;
      step_sync <= {step_sync[0], step};  // Shift in raw level
      step_last <= step_sync[1];
    end
  end

  // Rising edge on the synced level
  // Steps while not running are dropped so the phase stays put
  assign step_pulse = step_sync[1] & ~step_last & (state == ST_RUN);

  assign mode = state;

endmodule

//--- verilog/pwm_timer.sv
`timescale 1ns/1ps

module pwm_timer (
  input  logic               clk,
  input  logic               resetn,
  output stepper_pkg::duty_t carrier,       // Shared ramp for both coils
  output logic               period_start   // High while carrier is zero
);

  import stepper_pkg::*;

  duty_t count;  // Free-running, wraps every 2**DUTY_W clocks

  always_ff @(posedge clk) begin
    if (resetn) begin
      count <= '0;
    end else begin
      count <= count + duty_t'(1);  // Natural wrap, no terminal compare
    end
  end

  assign carrier = count;

  // Marks the first clock of each period
  assign period_start = (count == '0);

endmodule

//--- verilog/phase_accum.sv
`timescale 1ns/1ps

module phase_accum (
  input  logic                clk,
  input  logic                resetn,
  input  logic                step_pulse,  // One accepted step
  input  logic                dir,         // High counts up
  output stepper_pkg::phase_t phase
);

  import stepper_pkg::*;

  phase_t phase_q;
  phase_t phase_next;

  // Always one position per step
  always_comb begin
    phase_next = phase_q;
    if (step_pulse) begin
      if (dir) begin
        phase_next = phase_q + phase_t'(1);  // Wraps 255 to 0
      end else begin
        phase_next = phase_q - phase_t'(1);  // Wraps 0 to 255
      end
    end
  end

  always_ff @(posedge clk) begin
    if (resetn) begin
      phase_q <= '0;  // Start at coil B peak
    end else begin
      phase_q <= phase_next;
    end
  end

  assign phase = phase_q;

endmodule

//--- verilog/coil_amp.sv
`timescale 1ns/1ps

module coil_amp (
  input  logic                clk,
  input  logic                resetn,
  input  stepper_pkg::phase_t phase,
  input  stepper_pkg::cur_t   current,
  input  logic                period_start,
  output stepper_pkg::duty_t  duty_a,
  output stepper_pkg::duty_t  duty_b,
  output logic [1:0]          quadrant     // Goes with the latched duties
);

  import stepper_pkg::*;

  mag_t       lut [LUT_DEPTH];  // Quarter-wave cosine ROM
  phase_t     angle_a;
  mag_t       mag_a_q;          // Registered ROM reads
  mag_t       mag_b_q;
  logic [1:0] quad_q;
  duty_t      duty_a_calc;
  duty_t      duty_b_calc;

  initial begin
    $readmemb(LUT_FILE, lut);
  end

  // Quarter-wave fold, odd quadrants read the table backwards
  function automatic lut_idx_t fold_idx(input phase_t angle);
    lut_idx_t pos;
    pos = angle[LUT_IDX_W-1:0];
    if (angle[LUT_IDX_W]) begin
      return lut_idx_t'(QUAD_STEPS - 1) - pos;
    end
    return pos;
  endfunction

  assign angle_a = phase + phase_t'(QUAD_STEPS);  // Coil A one quadrant ahead

  // ROM read every clock
  always_ff @(posedge clk) begin
    mag_a_q <= lut[fold_idx(angle_a)];
    mag_b_q <= lut[fold_idx(phase)];
    quad_q  <= phase[PHASE_W-1 -: 2];  // Same clock as the reads
  end

  assign duty_a_calc = duty_t'(mag_a_q) * duty_t'(current);  // Max 255 * 15
  assign duty_b_calc = duty_t'(mag_b_q) * duty_t'(current);

  // Duty only moves at a period boundary
  always_ff @(posedge clk) begin
    if (resetn) begin
      duty_a   <= '0;
      duty_b   <= '0;
      quadrant <= 2'd0;
    end else if (period_start) begin
      duty_a   <= duty_a_calc;
      duty_b   <= duty_b_calc;
      quadrant <= quad_q;
    end
  end

endmodule

//--- verilog/hbridge_out.sv
`timescale 1ns/1ps

module hbridge_out (
  input  logic                     clk,
  input  logic                     resetn,
  input  bridge_pkg::drive_state_t mode,
  input  stepper_pkg::duty_t       carrier,
  input  stepper_pkg::duty_t       duty_a,
  input  stepper_pkg::duty_t       duty_b,
  input  logic [1:0]               quadrant,
  output logic                     phase_a1,
  output logic                     phase_a2,
  output logic                     phase_b1,
  output logic                     phase_b2,
  output logic                     vref_a,
  output logic                     vref_b
);

  import bridge_pkg::*;

  logic       cmp_a;       // Coil A on-time
  logic       cmp_b;       // Coil B on-time
  logic       run;
  logic [1:0] decay_pair;  // Pair value during off-time
  legs_t      quad_legs;
  legs_t      legs_next;
  legs_t      legs_q;

  assign cmp_a      = carrier < duty_a;
  assign cmp_b      = carrier < duty_b;
  assign run        = (mode == ST_RUN);
  assign decay_pair = SLOW_DECAY ? 2'b11 : 2'b00;
  assign quad_legs  = QUAD_LEGS[quadrant];

  // Legs and vref formed from the same compare, so they register together
  always_comb begin
    case (mode)
      ST_RUN: begin
        legs_next[1:0] = cmp_a ? quad_legs[1:0] : decay_pair;
        legs_next[3:2] = cmp_b ? quad_legs[3:2] : decay_pair;
      end
      ST_BRAKE: legs_next = 4'b1111;  // All legs high
      default:  legs_next = 4'b0000;  // Coast
    endcase
  end

  always_ff @(posedge clk) begin
    if (resetn) begin
      legs_q <= '0;
      vref_a <= 1'b0;
      vref_b <= 1'b0;
    end else begin
      legs_q <= legs_next;
      vref_a <= run & cmp_a;  // Low outside run
      vref_b <= run & cmp_b;
    end
  end

  assign {phase_b2, phase_b1, phase_a2, phase_a1} = legs_q;

endmodule

//--- verilog/stepper_drive.sv
`timescale 1ns/1ps

module stepper_drive (
  input  logic              clk,
  input  logic              resetn,
  input  logic              step,
  input  logic              dir,
  input  logic              enable,
  input  logic              brake,
  input  stepper_pkg::cur_t current,
  output logic              phase_a1,
  output logic              phase_a2,
  output logic              phase_b1,
  output logic              phase_b2,
  output logic              vref_a,
  output logic              vref_b
);

  import stepper_pkg::*;
  import bridge_pkg::*;

  drive_state_t mode;
  logic         step_pulse;
  phase_t       phase;
  duty_t        carrier;
  logic         period_start;
  duty_t        duty_a;
  duty_t        duty_b;
  logic [1:0]   quadrant;

  // Mode and step gating
  drive_fsm u_drive_fsm (
    .clk        (clk),
    .resetn     (resetn),
    .step       (step),
    .enable     (enable),
    .brake      (brake),
    .mode       (mode),
    .step_pulse (step_pulse)
  );

  pwm_timer u_pwm_timer (
    .clk          (clk),
    .resetn       (resetn),
    .carrier      (carrier),
    .period_start (period_start)
  );

  phase_accum u_phase_accum (
    .clk        (clk),
    .resetn     (resetn),
    .step_pulse (step_pulse),
    .dir        (dir),
    .phase      (phase)
  );

  coil_amp u_coil_amp (
    .clk          (clk),
    .resetn       (resetn),
    .phase        (phase),
    .current      (current),
    .period_start (period_start),
    .duty_a       (duty_a),
    .duty_b       (duty_b),
    .quadrant     (quadrant)
  );

  // Only driver of the bridge legs
  hbridge_out u_hbridge_out (
    .clk      (clk),
    .resetn   (resetn),
    .mode     (mode),
    .carrier  (carrier),
    .duty_a   (duty_a),
    .duty_b   (duty_b),
    .quadrant (quadrant),
    .phase_a1 (phase_a1),
    .phase_a2 (phase_a2),
    .phase_b1 (phase_b1),
    .phase_b2 (phase_b2),
    .vref_a   (vref_a),
    .vref_b   (vref_b)
  );

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  localparam time HALF_PERIOD = 20ns;  // 40 ns period

  initial begin
    clk = 1'b0;
  end

  always #(HALF_PERIOD) clk = ~clk;

endmodule

//--- tb/stepper_drive_assertions.sv
`timescale 1ns/1ps

module stepper_drive_assertions (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     enable,
  input  logic                     brake,
  input  bridge_pkg::drive_state_t mode,
  input  stepper_pkg::duty_t       carrier,
  input  logic                     phase_a1,
  input  logic                     phase_a2,
  input  logic                     phase_b1,
  input  logic                     phase_b2,
  input  logic                     vref_a,
  input  logic                     vref_b,
  input  logic [1:0]               exp_quad,    // Quadrant of the model phase
  input  stepper_pkg::duty_t       exp_duty_a,
  input  stepper_pkg::duty_t       exp_duty_b,
  input  logic                     chk_pol,     // Quadrant settled
  input  logic                     chk_duty     // Duty settled for a full period
);

  import stepper_pkg::*;
  import bridge_pkg::*;

  legs_t       legs;
  legs_t       pol;
  logic        seen_drive;  // Enable or brake raised since reset
  logic [1:0]  brake_cnt;   // Saturating count of brake request cycles
  logic        run_q;       // Mode behind the registered outputs
  logic [12:0] hi_cnt_a;    // vref high samples in this period
  logic [12:0] hi_cnt_b;
  logic [12:0] last_cnt_a;  // Count of the last finished period
  logic [12:0] last_cnt_b;
  logic        fail_off    = 1'b0;
  logic        fail_brake  = 1'b0;
  logic        fail_pol_a  = 1'b0;
  logic        fail_pol_b  = 1'b0;
  logic        fail_mix_a  = 1'b0;
  logic        fail_mix_b  = 1'b0;
  logic        fail_duty_a = 1'b0;
  logic        fail_duty_b = 1'b0;

  assign legs = {phase_b2, phase_b1, phase_a2, phase_a1};
  assign pol  = QUAD_LEGS[exp_quad];

  always_ff @(posedge clk) begin
    if (resetn) begin
      seen_drive <= 1'b0;
      brake_cnt  <= 2'd0;
      run_q      <= 1'b0;
      hi_cnt_a   <= '0;
      hi_cnt_b   <= '0;
      last_cnt_a <= '0;
      last_cnt_b <= '0;
    end else begin
      if (enable || brake) begin
        seen_drive <= 1'b1;
      end
      if (!enable && brake) begin
        if (brake_cnt != 2'd3) begin
          brake_cnt <= brake_cnt + 2'd1;
        end
      end else begin
        brake_cnt <= 2'd0;
      end
      run_q <= (mode == ST_RUN);
      // Window runs carrier 1 to 0 as vref lags one clock
      if (carrier == duty_t'(1)) begin
        hi_cnt_a <= {12'd0, vref_a};
        hi_cnt_b <= {12'd0, vref_b};
      end else begin
        hi_cnt_a <= hi_cnt_a + {12'd0, vref_a};
        hi_cnt_b <= hi_cnt_b + {12'd0, vref_b};
      end
      if (carrier == '0) begin
        last_cnt_a <= hi_cnt_a + {12'd0, vref_a};
        last_cnt_b <= hi_cnt_b + {12'd0, vref_b};
      end
    end
  end

  // Quiet until first drive request
  assert property (@(posedge clk) disable iff (resetn)
    !seen_drive |-> ({legs, vref_a, vref_b} == 6'd0))
    else begin
      $error("outputs not low before first drive request");
      fail_off = 1'b1;
    end

  assert property (@(posedge clk) disable iff (resetn)
    (brake_cnt >= 2'd2) |-> (legs == 4'hF && !vref_a && !vref_b))
    else begin
      $error("brake pattern missing");
      fail_brake = 1'b1;
    end

  assert property (@(posedge clk) disable iff (resetn)
    (chk_pol && run_q && vref_a) |-> (legs[1:0] == pol[1:0]))
    else begin
      $error("coil A polarity wrong");
      fail_pol_a = 1'b1;
    end

  assert property (@(posedge clk) disable iff (resetn)
    (chk_pol && run_q && vref_b) |-> (legs[3:2] == pol[3:2]))
    else begin
      $error("coil B polarity wrong");
      fail_pol_b = 1'b1;
    end

  // Pair shorted only during decay
  assert property (@(posedge clk) disable iff (resetn)
    run_q |-> (vref_a ? legs[1:0] != 2'b11 : legs[1:0] == {2{SLOW_DECAY}}))
    else begin
      $error("coil A leg pair conflict");
      fail_mix_a = 1'b1;
    end

  assert property (@(posedge clk) disable iff (resetn)
    run_q |-> (vref_b ? legs[3:2] != 2'b11 : legs[3:2] == {2{SLOW_DECAY}}))
    else begin
      $error("coil B leg pair conflict");
      fail_mix_b = 1'b1;
    end

  assert property (@(posedge clk) disable iff (resetn)
    (chk_duty && carrier == '0) |-> (hi_cnt_a + {12'd0, vref_a} == {1'b0, exp_duty_a}))
    else begin
      $error("coil A on-time wrong");
      fail_duty_a = 1'b1;
    end

  assert property (@(posedge clk) disable iff (resetn)
    (chk_duty && carrier == '0) |-> (hi_cnt_b + {12'd0, vref_b} == {1'b0, exp_duty_b}))
    else begin
      $error("coil B on-time wrong");
      fail_duty_b = 1'b1;
    end

endmodule

//--- tb/stepper_drive_tb.sv
`timescale 1ns/1ps

module stepper_drive_tb;

  import stepper_pkg::*;
  import bridge_pkg::*;

  localparam real PI             = 3.14159265358979;
  localparam int  PERIOD_TIMEOUT = 5000;  // One carrier period plus margin
  localparam int  N_BURSTS       = 6;

  logic       clk;
  logic       resetn;
  logic       step;
  logic       dir;
  logic       enable;
  logic       brake;
  cur_t       current;
  logic       phase_a1;
  logic       phase_a2;
  logic       phase_b1;
  logic       phase_b2;
  logic       vref_a;
  logic       vref_b;
  phase_t     model_phase;  // Phase as the pulses issued predict it
  logic [1:0] exp_quad;
  duty_t      exp_duty_a;
  duty_t      exp_duty_b;
  logic       chk_pol;
  logic       chk_duty;
  int         n_steps;

  tb_clock u_tb_clock (.clk(clk));

  stepper_drive u_stepper_drive (
    .clk(clk), .resetn(resetn), .step(step), .dir(dir), .enable(enable), .brake(brake),
    .current(current), .phase_a1(phase_a1), .phase_a2(phase_a2), .phase_b1(phase_b1),
    .phase_b2(phase_b2), .vref_a(vref_a), .vref_b(vref_b)
  );

  bind stepper_drive stepper_drive_assertions u_stepper_drive_assertions (
    .clk(clk), .resetn(resetn), .enable(enable), .brake(brake), .mode(mode),
    .carrier(carrier), .phase_a1(phase_a1), .phase_a2(phase_a2), .phase_b1(phase_b1),
    .phase_b2(phase_b2), .vref_a(vref_a), .vref_b(vref_b),
    .exp_quad(stepper_drive_tb.exp_quad), .exp_duty_a(stepper_drive_tb.exp_duty_a),
    .exp_duty_b(stepper_drive_tb.exp_duty_b), .chk_pol(stepper_drive_tb.chk_pol),
    .chk_duty(stepper_drive_tb.chk_duty)
  );

  // Table entry i sits at i/63 of a quarter wave
  function automatic int cos_mag(input int idx);
    return $rtoi(255.0 * $cos(real'(idx) * PI / 126.0) + 0.5);
  endfunction

  function automatic int fold_index(input phase_t angle);
    int pos;
    pos = int'(angle) % QUAD_STEPS;
    if (angle[6]) begin
      pos = QUAD_STEPS - 1 - pos;  // Odd quadrant runs backwards
    end
    return pos;
  endfunction

  task automatic update_expect();
    exp_quad   = model_phase[7:6];
    exp_duty_a = duty_t'(cos_mag(fold_index(model_phase + phase_t'(QUAD_STEPS))) * int'(current));
    exp_duty_b = duty_t'(cos_mag(fold_index(model_phase)) * int'(current));
  endtask

  task automatic tick();
    @(posedge clk);
    #2;  // Drive and look after the edge
  endtask

  task automatic stop_failed();
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at first error");
  endtask

  function automatic logic any_fail();
    return u_stepper_drive.u_stepper_drive_assertions.fail_off
      | u_stepper_drive.u_stepper_drive_assertions.fail_brake
      | u_stepper_drive.u_stepper_drive_assertions.fail_pol_a
      | u_stepper_drive.u_stepper_drive_assertions.fail_pol_b
      | u_stepper_drive.u_stepper_drive_assertions.fail_mix_a
      | u_stepper_drive.u_stepper_drive_assertions.fail_mix_b
      | u_stepper_drive.u_stepper_drive_assertions.fail_duty_a
      | u_stepper_drive.u_stepper_drive_assertions.fail_duty_b;
  endfunction

  task automatic report_fail();
    legs_t pol;
    pol = QUAD_LEGS[exp_quad];
    if (u_stepper_drive.u_stepper_drive_assertions.fail_off)
      $display("[FAIL] %0t outputs expected 000000 actual %b", $time,
               {phase_b2, phase_b1, phase_a2, phase_a1, vref_a, vref_b});
    if (u_stepper_drive.u_stepper_drive_assertions.fail_brake)
      $display("[FAIL] %0t legs expected 1111 actual %b", $time,
               {phase_b2, phase_b1, phase_a2, phase_a1});
    if (u_stepper_drive.u_stepper_drive_assertions.fail_pol_a)
      $display("[FAIL] %0t phase_a2_a1 expected %b actual %b", $time, pol[1:0],
               {phase_a2, phase_a1});
    if (u_stepper_drive.u_stepper_drive_assertions.fail_pol_b)
      $display("[FAIL] %0t phase_b2_b1 expected %b actual %b", $time, pol[3:2],
               {phase_b2, phase_b1});
    if (u_stepper_drive.u_stepper_drive_assertions.fail_mix_a)
      $display("[FAIL] %0t phase_a2_a1 expected %s actual %b", $time,
               vref_a ? "not 11" : "11", {phase_a2, phase_a1});
    if (u_stepper_drive.u_stepper_drive_assertions.fail_mix_b)
      $display("[FAIL] %0t phase_b2_b1 expected %s actual %b", $time,
               vref_b ? "not 11" : "11", {phase_b2, phase_b1});
    if (u_stepper_drive.u_stepper_drive_assertions.fail_duty_a)
      $display("[FAIL] %0t vref_a high clocks expected %0d actual %0d", $time, exp_duty_a,
               u_stepper_drive.u_stepper_drive_assertions.last_cnt_a);
    if (u_stepper_drive.u_stepper_drive_assertions.fail_duty_b)
      $display("[FAIL] %0t vref_b high clocks expected %0d actual %0d", $time, exp_duty_b,
               u_stepper_drive.u_stepper_drive_assertions.last_cnt_b);
    stop_failed();
  endtask

  // Wait for carrier zero, bounded
  task automatic wait_period_start();
    int n;
    n = 0;
    tick();
    while (u_stepper_drive.carrier != '0) begin
      if (n == PERIOD_TIMEOUT) begin
        $display("Timeout: no PWM period start within %0d clocks", PERIOD_TIMEOUT);
        stop_failed();
      end
      tick();
      n++;
    end
  endtask

  // 2 clocks high, 8 low per pulse
  task automatic issue_steps(input int n, input logic d);
    dir = d;
    for (int i = 0; i < n; i++) begin
      step = 1'b1;
      repeat (2) tick();
      step = 1'b0;
      repeat (8) tick();
      if (enable) begin
        model_phase = d ? model_phase + phase_t'(1) : model_phase - phase_t'(1);
      end
    end
  endtask

  // Let the new quadrant and duty reach the bridges
  task automatic settle_outputs();
    repeat (8) tick();
    wait_period_start();
    wait_period_start();
    repeat (2) tick();
    update_expect();
  endtask

  always begin
    @(posedge clk);
    #1;
    if (any_fail()) report_fail();
  end

  initial begin
    resetn      = 1'b1;
    step        = 1'b0;
    dir         = 1'b0;
    enable      = 1'b0;
    brake       = 1'b0;
    current     = 4'd15;
    model_phase = '0;
    exp_quad    = 2'd0;
    exp_duty_a  = '0;
    exp_duty_b  = '0;
    chk_pol     = 1'b0;
    chk_duty    = 1'b0;
    void'($urandom(18223));
    repeat (16) tick();
    resetn = 1'b0;
    repeat (20) tick();       // Off state after reset
    brake = 1'b1;
    repeat (20) tick();
    brake = 1'b0;
    repeat (10) tick();
    enable = 1'b1;
    repeat (4) tick();
    for (int b = 0; b < N_BURSTS; b++) begin
      chk_pol = 1'b0;
      current = cur_t'($urandom_range(1, 15));
      n_steps = $urandom_range(1, 40);
      issue_steps(n_steps, $urandom_range(0, 1) == 1);
      settle_outputs();
      chk_pol = 1'b1;
      wait_period_start();
    end
    chk_pol = 1'b0;
    // Back to phase 0 the short way
    if (model_phase < 8'd128) issue_steps(int'(model_phase), 1'b0);
    else issue_steps(256 - int'(model_phase), 1'b1);
    current = 4'd15;
    settle_outputs();
    chk_duty = 1'b1;
    wait_period_start();
    wait_period_start();
    chk_duty = 1'b0;
    current  = 4'd0;          // Both coils silent
    settle_outputs();
    chk_duty = 1'b1;
    wait_period_start();
    wait_period_start();
    chk_duty = 1'b0;
    enable   = 1'b0;          // Brake out of run
    brake    = 1'b1;
    repeat (10) tick();
    if (any_fail()) begin
      report_fail();
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

//--- cos_lut.mem
// Quarter-wave cosine magnitude, one 8-bit binary entry per line
// Index 0 is the peak of 255, index 63 is the zero crossing
11111111
11111111
11111111
11111110
11111110
11111101
11111100
11111011
11111010
11111001
11110111
11110101
11110100
11110010
11110000
11101101
11101011
11101000
11100110
11100011
11100000
11011101
11011010
11010110
11010011
11001111
11001011
11000111
11000011
10111111
10111011
10110111
10110010
10101101
10101001
10100100
10011111
10011010
10010101
10010000
10001010
10000101
10000000
01111010
01110100
01101111
01101001
01100011
01011101
01010111
01010001
01001011
01000101
00111111
00111001
00110011
00101100
00100110
00100000
00011001
00010011
00001101
00000110
00000000

//--- vlog.f
verilog/stepper_pkg.sv
verilog/bridge_pkg.sv
verilog/drive_fsm.sv
verilog/pwm_timer.sv
verilog/phase_accum.sv
verilog/coil_amp.sv
verilog/hbridge_out.sv
verilog/stepper_drive.sv
tb/tb_clock.sv
tb/stepper_drive_assertions.sv
tb/stepper_drive_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module stepper_drive_tb -f vlog.f \
  -o stepper_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/stepper_sim > sim.log 2>&1
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0
